/* logic/rv_decode_pkg.sv */
package rv_decode_pkg;

	localparam int WORD_WIDTH   = 32;                         // data and instruction width.
	localparam int ADDR_WIDTH   = 5;                          // register index width.
	localparam int NUM_REGS     = 1 << ADDR_WIDTH;            // x0 to x31.
	localparam int QUEUE_DEPTH  = 2;                          // also the fetch credit count.
	localparam int QPTR_WIDTH   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int QCNT_WIDTH   = $clog2(QUEUE_DEPTH + 1);    // holds 0 to QUEUE_DEPTH.
	localparam int EX_CREDITS   = 2;                          // packets execute can buffer.
	localparam int CREDIT_WIDTH = 2;

	localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;     // sub and sra.
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;     // M extension.

	typedef logic [WORD_WIDTH-1:0]   word_t;
	typedef logic [ADDR_WIDTH-1:0]   reg_addr_t;
	typedef logic [CREDIT_WIDTH-1:0] credit_cnt_t;

	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_AUIPC  = 7'b0010111,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10      // operand b straight through for lui.
	} alu_op_e;

	// encoded as funct3 of the M extension
	typedef enum logic [2:0] {
		MD_MUL    = 3'b000,
		MD_MULH   = 3'b001,
		MD_MULHSU = 3'b010,
		MD_MULHU  = 3'b011,
		MD_DIV    = 3'b100,
		MD_DIVU   = 3'b101,
		MD_REM    = 3'b110,
		MD_REMU   = 3'b111
	} md_op_e;

	typedef struct packed {
		alu_op_e    alu_op;
		logic       reg_write;
		logic       alu_src_imm;    // operand b from the immediate.
		logic       alu_src_pc;     // operand a from the pc.
		logic       is_load;
		logic [2:0] load_type;      // funct3 of the load.
		logic       is_store;
		logic [1:0] store_type;     // byte, half or word.
		logic       branch;
		logic       branch_inv;     // take on a false compare.
		logic       jal;
		logic       jalr;
		logic       mdu;
		md_op_e     md_op;
		logic       illegal;
	} ctrl_t;

	typedef struct packed {
		word_t instr;
		word_t pc_plus4;
	} fetch_pkt_t;

	typedef struct packed {
		word_t     pc_plus4;
		word_t     rs1_data;
		word_t     rs2_data;
		word_t     imm;
		reg_addr_t rd;
		ctrl_t     ctrl;
	} id_ex_pkt_t;

	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} wb_pkt_t;

endpackage

/* logic/control_unit.sv */
`timescale 1ns/100ps

module control_unit (
	input  rv_decode_pkg::word_t instr_i,
	output rv_decode_pkg::ctrl_t ctrl_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	// shared by op and op-imm when funct7 is the base encoding
	function automatic rv_decode_pkg::alu_op_e base_alu_op(input logic [2:0] f3);
		rv_decode_pkg::alu_op_e op;
		case (f3)
			3'b000:  op = rv_decode_pkg::ALU_ADD;
			3'b001:  op = rv_decode_pkg::ALU_SLL;
			3'b010:  op = rv_decode_pkg::ALU_SLT;
			3'b011:  op = rv_decode_pkg::ALU_SLTU;
			3'b100:  op = rv_decode_pkg::ALU_XOR;
			3'b101:  op = rv_decode_pkg::ALU_SRL;
			3'b110:  op = rv_decode_pkg::ALU_OR;
			default: op = rv_decode_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		ctrl_o        = '0;
		ctrl_o.alu_op = rv_decode_pkg::ALU_ADD;
		ctrl_o.md_op  = rv_decode_pkg::MD_MUL;
		case (opcode)
			rv_decode_pkg::OPC_LUI: begin
				ctrl_o.reg_write   = 1'b1;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.alu_op      = rv_decode_pkg::ALU_PASS_B;
			end
			rv_decode_pkg::OPC_AUIPC, rv_decode_pkg::OPC_JAL: begin
				ctrl_o.reg_write   = 1'b1;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.alu_src_pc  = 1'b1;                    // pc + imm.
				ctrl_o.jal         = (opcode == rv_decode_pkg::OPC_JAL);
			end
			rv_decode_pkg::OPC_JALR: begin
				ctrl_o.reg_write   = 1'b1;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.jalr        = 1'b1;
				ctrl_o.illegal     = (funct3 != 3'b000);
			end
			rv_decode_pkg::OPC_BRANCH: begin
				ctrl_o.branch     = 1'b1;
				ctrl_o.branch_inv = funct3[0];                // bne, bge, bgeu.
				case (funct3[2:1])
					2'b00:   ctrl_o.alu_op = rv_decode_pkg::ALU_SUB;   // zero test.
					2'b10:   ctrl_o.alu_op = rv_decode_pkg::ALU_SLT;
					2'b11:   ctrl_o.alu_op = rv_decode_pkg::ALU_SLTU;
					default: ctrl_o.illegal = 1'b1;
				endcase
			end
			rv_decode_pkg::OPC_LOAD: begin
				ctrl_o.reg_write   = 1'b1;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.is_load     = 1'b1;
				ctrl_o.load_type   = funct3;
				ctrl_o.illegal     = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
			end
			rv_decode_pkg::OPC_STORE: begin
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.is_store    = 1'b1;
				ctrl_o.store_type  = funct3[1:0];
				ctrl_o.illegal     = funct3[2] || (funct3[1:0] == 2'b11);
			end
			rv_decode_pkg::OPC_OP_IMM: begin
				ctrl_o.reg_write   = 1'b1;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.alu_op      = base_alu_op(funct3);
				if (funct3 == 3'b001) begin
					ctrl_o.illegal = (funct7 != rv_decode_pkg::FUNCT7_BASE);
				end else if (funct3 == 3'b101) begin
					if (funct7 == rv_decode_pkg::FUNCT7_ALT) begin
						ctrl_o.alu_op = rv_decode_pkg::ALU_SRA;
					end else begin
						ctrl_o.illegal = (funct7 != rv_decode_pkg::FUNCT7_BASE);
					end
				end
			end
			rv_decode_pkg::OPC_OP: begin
				ctrl_o.reg_write = 1'b1;
				if (funct7 == rv_decode_pkg::FUNCT7_BASE) begin
					ctrl_o.alu_op = base_alu_op(funct3);
				end else if (funct7 == rv_decode_pkg::FUNCT7_ALT && funct3 == 3'b000) begin
					ctrl_o.alu_op = rv_decode_pkg::ALU_SUB;
				end else if (funct7 == rv_decode_pkg::FUNCT7_ALT && funct3 == 3'b101) begin
					ctrl_o.alu_op = rv_decode_pkg::ALU_SRA;
				end else if (funct7 == rv_decode_pkg::FUNCT7_MULDIV) begin
					ctrl_o.mdu   = 1'b1;
					ctrl_o.md_op = rv_decode_pkg::md_op_e'(funct3);
				end else begin
					ctrl_o.illegal = 1'b1;
				end
			end
			default: ctrl_o.illegal = 1'b1;                  // csr, system, fence and the rest.
		endcase
		if (ctrl_o.illegal) begin                            // no side effects for unknown words.
			ctrl_o.reg_write = 1'b0;
			ctrl_o.is_load   = 1'b0;
			ctrl_o.is_store  = 1'b0;
			ctrl_o.branch    = 1'b0;
			ctrl_o.jal       = 1'b0;
			ctrl_o.jalr      = 1'b0;
		end
	end

endmodule

/* logic/reg_bank.sv */
`timescale 1ns/100ps

module reg_bank (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  rv_decode_pkg::reg_addr_t raddr1_i,
	input  rv_decode_pkg::reg_addr_t raddr2_i,
	output rv_decode_pkg::word_t     rdata1_o,
	output rv_decode_pkg::word_t     rdata2_o,
	input  rv_decode_pkg::wb_pkt_t   wb_i
);

	rv_decode_pkg::word_t regs [rv_decode_pkg::NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < rv_decode_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.we && wb_i.waddr != '0) begin  // x0 is never written.
			regs[wb_i.waddr] <= wb_i.wdata;
		end
	end

	// x0 first, then the same-cycle write, then the array
	function automatic rv_decode_pkg::word_t read_port(input rv_decode_pkg::reg_addr_t addr);
		rv_decode_pkg::word_t data;
		if (addr == '0) begin
			data = '0;
		end else if (wb_i.we && wb_i.waddr == addr) begin
			data = wb_i.wdata;                            // write-to-read bypass.
		end else begin
			data = regs[addr];
		end
		return data;
	endfunction

	always_comb rdata1_o = read_port(raddr1_i);
	always_comb rdata2_o = read_port(raddr2_i);

endmodule

/* logic/imm_gen.sv */
`timescale 1ns/100ps

module imm_gen (
	input  rv_decode_pkg::word_t instr_i,
	output rv_decode_pkg::word_t imm_o
);

	logic [6:0]           opcode;
	logic                 sign;
	rv_decode_pkg::word_t imm_i_type;
	rv_decode_pkg::word_t imm_s_type;
	rv_decode_pkg::word_t imm_b_type;
	rv_decode_pkg::word_t imm_u_type;
	rv_decode_pkg::word_t imm_j_type;

	assign opcode = instr_i[6:0];
	assign sign   = instr_i[31];                        // all formats sign from bit 31.

	assign imm_i_type = {{20{sign}}, instr_i[31:20]};
	assign imm_s_type = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b_type = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u_type = {instr_i[31:12], 12'b0};
	assign imm_j_type = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	always_comb begin
		case (opcode)
			rv_decode_pkg::OPC_LOAD,
			rv_decode_pkg::OPC_OP_IMM,
			rv_decode_pkg::OPC_JALR:   imm_o = imm_i_type;
			rv_decode_pkg::OPC_STORE:  imm_o = imm_s_type;
			rv_decode_pkg::OPC_BRANCH: imm_o = imm_b_type;
			rv_decode_pkg::OPC_LUI,
			rv_decode_pkg::OPC_AUIPC:  imm_o = imm_u_type;
			rv_decode_pkg::OPC_JAL:    imm_o = imm_j_type;
			default:                   imm_o = '0;          // r-type and unknown words.
		endcase
	end

endmodule

/* logic/instr_queue.sv */
`timescale 1ns/100ps

module instr_queue (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      push_i,
	input  rv_decode_pkg::fetch_pkt_t push_pkt_i,
	input  logic                      pop_i,
	output rv_decode_pkg::fetch_pkt_t head_o,
	output logic                      empty_o,
	output logic                      credit_o
);

	localparam logic [rv_decode_pkg::QPTR_WIDTH-1:0] LAST_SLOT =
		rv_decode_pkg::QPTR_WIDTH'(rv_decode_pkg::QUEUE_DEPTH - 1);

	rv_decode_pkg::fetch_pkt_t                mem [rv_decode_pkg::QUEUE_DEPTH];
	logic [rv_decode_pkg::QPTR_WIDTH-1:0] wr_ptr;
	logic [rv_decode_pkg::QPTR_WIDTH-1:0] rd_ptr;
	logic [rv_decode_pkg::QCNT_WIDTH-1:0] count;

	always_ff @(posedge clk) begin
		if (push_i) begin
			mem[wr_ptr] <= push_pkt_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			credit_o <= pop_i;                          // one credit back per pop.
			if (push_i) begin
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_i) begin
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;                // both or neither.
			endcase
		end
	end

	assign head_o  = mem[rd_ptr];
	assign empty_o = (count == '0);

endmodule

/* logic/id_stage.sv */
`timescale 1ns/100ps

module id_stage (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      fetch_valid_i,
	input  rv_decode_pkg::fetch_pkt_t fetch_pkt_i,
	output logic                      fetch_credit_o,
	input  rv_decode_pkg::wb_pkt_t    wb_i,
	output logic                      ex_valid_o,
	output rv_decode_pkg::id_ex_pkt_t ex_pkt_o,
	input  logic                      ex_credit_i
);

	rv_decode_pkg::fetch_pkt_t  head;
	logic                       q_empty;
	logic                       issue;
	rv_decode_pkg::credit_cnt_t ex_credits;
	rv_decode_pkg::word_t       rs1_data;
	rv_decode_pkg::word_t       rs2_data;
	rv_decode_pkg::word_t       imm;
	rv_decode_pkg::ctrl_t       ctrl;
	rv_decode_pkg::id_ex_pkt_t  next_pkt;

	assign issue = !q_empty && (ex_credits != '0);  // head leaves when execute has room.

	instr_queue queue (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.push_i     (fetch_valid_i),
		.push_pkt_i (fetch_pkt_i),
		.pop_i      (issue),
		.head_o     (head),
		.empty_o    (q_empty),
		.credit_o   (fetch_credit_o)
	);

	reg_bank regbank (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.raddr1_i (head.instr[19:15]),
		.raddr2_i (head.instr[24:20]),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data),
		.wb_i     (wb_i)
	);

	imm_gen immgen (
		.instr_i (head.instr),
		.imm_o   (imm)
	);

	control_unit ctrl_unit (
		.instr_i (head.instr),
		.ctrl_o  (ctrl)
	);

	always_comb begin
		next_pkt.pc_plus4 = head.pc_plus4;              // link value for jal and jalr.
		next_pkt.rs1_data = rs1_data;
		next_pkt.rs2_data = rs2_data;
		next_pkt.imm      = imm;
		next_pkt.rd       = head.instr[11:7];
		next_pkt.ctrl     = ctrl;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ex_valid_o <= 1'b0;
			ex_credits <= rv_decode_pkg::CREDIT_WIDTH'(rv_decode_pkg::EX_CREDITS);
		end else begin
			ex_valid_o <= issue;
			case ({issue, ex_credit_i})
				2'b10:   ex_credits <= ex_credits - 1'b1;
				2'b01:   ex_credits <= ex_credits + 1'b1;
				default: ex_credits <= ex_credits;       // issue and return cancel out.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			ex_pkt_o <= next_pkt;
		end
	end

endmodule

/* logic/rv_decode_top.sv */
`timescale 1ns/100ps

module rv_decode_top (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      fetch_valid_i,
	input  rv_decode_pkg::fetch_pkt_t fetch_pkt_i,
	output logic                      fetch_credit_o,
	input  rv_decode_pkg::wb_pkt_t    wb_i,
	output logic                      ex_valid_o,
	output rv_decode_pkg::id_ex_pkt_t ex_pkt_o,
	input  logic                      ex_credit_i
);

	// decode stage between fetch, write-back and execute
	id_stage decode (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.fetch_valid_i  (fetch_valid_i),
		.fetch_pkt_i    (fetch_pkt_i),
		.fetch_credit_o (fetch_credit_o),
		.wb_i           (wb_i),
		.ex_valid_o     (ex_valid_o),
		.ex_pkt_o       (ex_pkt_o),
		.ex_credit_i    (ex_credit_i)
	);

endmodule

/* bench/rv_decode_model.svh */
`ifndef RV_DECODE_MODEL_SVH
`define RV_DECODE_MODEL_SVH

rv_decode_pkg::word_t shadow_regs [rv_decode_pkg::NUM_REGS];  // register contents as seen by execute.

function automatic void shadow_clear();
	for (int i = 0; i < rv_decode_pkg::NUM_REGS; i++) begin
		shadow_regs[i] = '0;
	end
endfunction

function automatic void shadow_write(input rv_decode_pkg::wb_pkt_t wb);
	if (wb.we && wb.waddr != '0) begin
		shadow_regs[wb.waddr] = wb.wdata;
	end
endfunction

function automatic rv_decode_pkg::word_t shadow_read(input rv_decode_pkg::reg_addr_t addr);
	return (addr == '0) ? '0 : shadow_regs[addr];  // x0 reads zero whatever was written.
endfunction

// immediate per instruction format with the sign from the top bit of each field
function automatic rv_decode_pkg::word_t expected_imm(input rv_decode_pkg::word_t instr);
	logic signed [11:0] i12;
	logic signed [11:0] s12;
	logic signed [12:0] b13;
	logic signed [20:0] j21;
	rv_decode_pkg::word_t imm;
	i12 = instr[31:20];
	s12 = {instr[31:25], instr[11:7]};
	b13 = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	j21 = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	case (instr[6:0])
		rv_decode_pkg::OPC_LOAD, rv_decode_pkg::OPC_OP_IMM, rv_decode_pkg::OPC_JALR:
			imm = 32'(i12);
		rv_decode_pkg::OPC_STORE:  imm = 32'(s12);
		rv_decode_pkg::OPC_BRANCH: imm = 32'(b13);
		rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC:
			imm = {instr[31:12], 12'h000};
		rv_decode_pkg::OPC_JAL:    imm = 32'(j21);
		default:                   imm = '0;
	endcase
	return imm;
endfunction

function automatic rv_decode_pkg::ctrl_t expected_ctrl(input rv_decode_pkg::word_t instr);
	rv_decode_pkg::ctrl_t c;
	logic [2:0] f3;
	logic [6:0] f7;
	f3       = instr[14:12];
	f7       = instr[31:25];
	c        = '0;
	c.alu_op = rv_decode_pkg::ALU_ADD;
	c.md_op  = rv_decode_pkg::MD_MUL;
	case (instr[6:0])
		rv_decode_pkg::OPC_LUI: begin
			c.reg_write   = 1'b1;
			c.alu_src_imm = 1'b1;
			c.alu_op      = rv_decode_pkg::ALU_PASS_B;
		end
		rv_decode_pkg::OPC_AUIPC: begin
			c.reg_write   = 1'b1;
			c.alu_src_imm = 1'b1;
			c.alu_src_pc  = 1'b1;
		end
		rv_decode_pkg::OPC_JAL: begin
			c.reg_write   = 1'b1;
			c.alu_src_imm = 1'b1;
			c.alu_src_pc  = 1'b1;
			c.jal         = 1'b1;
		end
		rv_decode_pkg::OPC_JALR: begin
			c.reg_write   = 1'b1;
			c.alu_src_imm = 1'b1;
			c.jalr        = 1'b1;
			c.illegal     = (f3 != 3'b000);
		end
		rv_decode_pkg::OPC_BRANCH: begin
			c.branch     = 1'b1;
			c.branch_inv = f3[0];                       // bne, bge and bgeu.
			case (f3)
				3'b000, 3'b001: c.alu_op = rv_decode_pkg::ALU_SUB;
				3'b100, 3'b101: c.alu_op = rv_decode_pkg::ALU_SLT;
				3'b110, 3'b111: c.alu_op = rv_decode_pkg::ALU_SLTU;
				default:        c.illegal = 1'b1;
			endcase
		end
		rv_decode_pkg::OPC_LOAD: begin
			c.reg_write   = 1'b1;
			c.alu_src_imm = 1'b1;
			c.is_load     = 1'b1;
			c.load_type   = f3;
			c.illegal     = !(f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
		end
		rv_decode_pkg::OPC_STORE: begin
			c.alu_src_imm = 1'b1;
			c.is_store    = 1'b1;
			c.store_type  = f3[1:0];
			c.illegal     = !(f3 inside {3'b000, 3'b001, 3'b010});
		end
		rv_decode_pkg::OPC_OP_IMM: begin
			c.reg_write   = 1'b1;
			c.alu_src_imm = 1'b1;
			case (f3)
				3'b000: c.alu_op = rv_decode_pkg::ALU_ADD;
				3'b010: c.alu_op = rv_decode_pkg::ALU_SLT;
				3'b011: c.alu_op = rv_decode_pkg::ALU_SLTU;
				3'b100: c.alu_op = rv_decode_pkg::ALU_XOR;
				3'b110: c.alu_op = rv_decode_pkg::ALU_OR;
				3'b111: c.alu_op = rv_decode_pkg::ALU_AND;
				3'b001: begin
					c.alu_op  = rv_decode_pkg::ALU_SLL;
					c.illegal = (f7 != 7'b0000000);
				end
				default: begin                          // srli and srai.
					c.alu_op  = (f7 == 7'b0100000) ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
					c.illegal = !(f7 inside {7'b0000000, 7'b0100000});
				end
			endcase
		end
		rv_decode_pkg::OPC_OP: begin
			c.reg_write = 1'b1;
			if (f7 == 7'b0000001) begin
				c.mdu   = 1'b1;
				c.md_op = rv_decode_pkg::md_op_e'(f3);
			end else begin
				case ({f7, f3})
					10'b0000000_000: c.alu_op = rv_decode_pkg::ALU_ADD;
					10'b0100000_000: c.alu_op = rv_decode_pkg::ALU_SUB;
					10'b0000000_001: c.alu_op = rv_decode_pkg::ALU_SLL;
					10'b0000000_010: c.alu_op = rv_decode_pkg::ALU_SLT;
					10'b0000000_011: c.alu_op = rv_decode_pkg::ALU_SLTU;
					10'b0000000_100: c.alu_op = rv_decode_pkg::ALU_XOR;
					10'b0000000_101: c.alu_op = rv_decode_pkg::ALU_SRL;
					10'b0100000_101: c.alu_op = rv_decode_pkg::ALU_SRA;
					10'b0000000_110: c.alu_op = rv_decode_pkg::ALU_OR;
					10'b0000000_111: c.alu_op = rv_decode_pkg::ALU_AND;
					default:         c.illegal = 1'b1;
				endcase
			end
		end
		default: c.illegal = 1'b1;
	endcase
	if (c.illegal) begin                                // unknown words have no side effects.
		c.reg_write = 1'b0;
		c.is_load   = 1'b0;
		c.is_store  = 1'b0;
		c.branch    = 1'b0;
		c.jal       = 1'b0;
		c.jalr      = 1'b0;
	end
	return c;
endfunction

function automatic rv_decode_pkg::id_ex_pkt_t expected_packet(input rv_decode_pkg::fetch_pkt_t f);
	rv_decode_pkg::id_ex_pkt_t p;
	p.pc_plus4 = f.pc_plus4;
	p.rs1_data = shadow_read(f.instr[19:15]);
	p.rs2_data = shadow_read(f.instr[24:20]);
	p.imm      = expected_imm(f.instr);
	p.rd       = f.instr[11:7];
	p.ctrl     = expected_ctrl(f.instr);
	return p;
endfunction

`endif

/* bench/tb_rv_decode.sv */
`timescale 1ns/100ps

module tb_rv_decode;

	localparam int CLK_PERIOD       = 4;
	localparam int RESET_CYCLES     = 4;
	localparam int NUM_INSTR        = 400;
	localparam int CYCLES_PER_INSTR = 20;
	localparam int WATCHDOG_NS      = (NUM_INSTR * CYCLES_PER_INSTR + RESET_CYCLES) * CLK_PERIOD;

	logic                      clk;
	logic                      rst_n_i;
	logic                      fetch_valid_i;
	rv_decode_pkg::fetch_pkt_t fetch_pkt_i;
	logic                      fetch_credit_o;
	rv_decode_pkg::wb_pkt_t    wb_i;
	logic                      ex_valid_o;
	rv_decode_pkg::id_ex_pkt_t ex_pkt_o;
	logic                      ex_credit_i;

	integer                    seed;
	bit                        checking;         // monitor runs once the first reset edge is seen.
	rv_decode_pkg::fetch_pkt_t pending_q [$];    // sent by fetch and not yet issued.
	rv_decode_pkg::word_t      next_pc;
	rv_decode_pkg::word_t      last_instr;
	int                        fetch_credits;
	int                        ex_outstanding;   // issued packets whose credit is not back.
	int                        credit_delay;
	int                        queued;           // entries the stage holds by the push and pop rule.
	int                        ex_credits_left;  // execute credits the stage holds.
	logic                      issue_exp;        // issue expected at the last rising edge.
	int                        sent;
	int                        issued;
	int                        credit_pulses;
	int                        pkt_errors;
	int                        ctrl_errors;
	int                        word_errors;
	int                        flag_errors;
	int                        proto_errors;

	`include "rv_decode_model.svh"

	rv_decode_top dut_i (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.fetch_valid_i  (fetch_valid_i),
		.fetch_pkt_i    (fetch_pkt_i),
		.fetch_credit_o (fetch_credit_o),
		.wb_i           (wb_i),
		.ex_valid_o     (ex_valid_o),
		.ex_pkt_o       (ex_pkt_o),
		.ex_credit_i    (ex_credit_i)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	// mostly well formed opcodes and one word in ten left fully random
	function automatic rv_decode_pkg::word_t random_instr();
		rv_decode_pkg::word_t w;
		w = $random(seed);
		if (rand_below(10) != 0) begin
			case (rand_below(9))
				0:       w[6:0] = rv_decode_pkg::OPC_LOAD;
				1:       w[6:0] = rv_decode_pkg::OPC_OP_IMM;
				2:       w[6:0] = rv_decode_pkg::OPC_AUIPC;
				3:       w[6:0] = rv_decode_pkg::OPC_STORE;
				4:       w[6:0] = rv_decode_pkg::OPC_OP;
				5:       w[6:0] = rv_decode_pkg::OPC_LUI;
				6:       w[6:0] = rv_decode_pkg::OPC_BRANCH;
				7:       w[6:0] = rv_decode_pkg::OPC_JALR;
				default: w[6:0] = rv_decode_pkg::OPC_JAL;
			endcase
			if (w[6:0] == rv_decode_pkg::OPC_OP || w[6:0] == rv_decode_pkg::OPC_OP_IMM) begin
				case (rand_below(4))
					0:       w[31:25] = rv_decode_pkg::FUNCT7_BASE;
					1:       w[31:25] = rv_decode_pkg::FUNCT7_ALT;
					2:       w[31:25] = rv_decode_pkg::FUNCT7_MULDIV;
					default: w[31:25] = w[31:25];          // keep the random funct7.
				endcase
			end
		end
		return w;
	endfunction

	task automatic check_word(input string name, input rv_decode_pkg::word_t got,
		input rv_decode_pkg::word_t exp);
		if (got !== exp) begin
			word_errors++;
			$display("Error %s: got %08h, expected %08h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_ctrl(input string name, input rv_decode_pkg::ctrl_t got,
		input rv_decode_pkg::ctrl_t exp);
		if (got !== exp) begin
			ctrl_errors++;
			$display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_pkt(input string name, input rv_decode_pkg::id_ex_pkt_t got,
		input rv_decode_pkg::id_ex_pkt_t exp);
		if (got !== exp) begin
			pkt_errors++;
			$display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			flag_errors++;
			$display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic protocol_error(input string what);
		proto_errors++;
		$display("%s at %0t", what, $time);
	endtask

	function automatic int total_errors();
		return pkt_errors + ctrl_errors + word_errors + flag_errors + proto_errors;
	endfunction

	task automatic report_counts();
		$display("packets %0d of %0d, errors pkt %0d ctrl %0d word %0d flag %0d protocol %0d",
			issued, NUM_INSTR, pkt_errors, ctrl_errors, word_errors, flag_errors, proto_errors);
	endtask

	// the stage issues while it holds both a queued entry and an execute credit
	task automatic predict_issue();
		issue_exp       = (queued > 0 && ex_credits_left > 0);
		queued          = queued + int'(fetch_valid_i) - int'(issue_exp);
		ex_credits_left = ex_credits_left + int'(ex_credit_i) - int'(issue_exp);
	endtask

	// aims some writes at the registers of the instruction sent last cycle
	task automatic drive_writeback();
		rv_decode_pkg::wb_pkt_t wb;
		int                     pick;
		pick     = int'(rand_below(8));
		wb.we    = (pick < 5);
		wb.wdata = $random(seed);
		case (pick)
			0:       wb.waddr = last_instr[19:15];
			1:       wb.waddr = last_instr[24:20];
			2:       wb.waddr = '0;                      // x0 must stay zero.
			default: wb.waddr = rv_decode_pkg::reg_addr_t'(rand_below(32));
		endcase
		wb_i <= wb;
	endtask

	task automatic drive_fetch();
		rv_decode_pkg::fetch_pkt_t pkt;
		if (sent < NUM_INSTR && fetch_credits > 0 && rand_below(4) != 0) begin
			pkt.instr    = random_instr();
			pkt.pc_plus4 = next_pc;
			next_pc      = next_pc + 32'd4;
			pending_q.push_back(pkt);
			fetch_credits--;
			sent++;
			last_instr    = pkt.instr;
			fetch_valid_i <= 1'b1;
			fetch_pkt_i   <= pkt;
		end else begin
			fetch_valid_i <= 1'b0;
		end
	endtask

	// execute side with now and then a long stall
	task automatic return_credit();
		if (ex_outstanding > 0 && credit_delay == 0) begin
			ex_credit_i <= 1'b1;
			ex_outstanding--;
			credit_delay = (rand_below(16) == 0) ? int'(20 + rand_below(20)) : int'(rand_below(3));
		end else begin
			ex_credit_i <= 1'b0;
			if (credit_delay > 0) begin
				credit_delay--;
			end
		end
	endtask

	task automatic check_outputs();
		rv_decode_pkg::fetch_pkt_t  src;
		rv_decode_pkg::id_ex_pkt_t  exp;
		check_flag("ex_valid_o", ex_valid_o, issue_exp);
		check_flag("fetch_credit_o", fetch_credit_o, issue_exp);  // pulse with the popped entry.
		if (fetch_credit_o === 1'b1) begin
			credit_pulses++;
			fetch_credits++;
			if (fetch_credits > rv_decode_pkg::QUEUE_DEPTH) begin
				protocol_error("fetch got back more credits than it spent");
			end
		end
		if (ex_valid_o === 1'b1) begin
			if (pending_q.size() == 0) begin
				protocol_error("a packet was issued with no instruction pending");
			end else begin
				src = pending_q.pop_front();
				exp = expected_packet(src);
				check_ctrl("ex_pkt_o.ctrl", ex_pkt_o.ctrl, exp.ctrl);
				check_word("ex_pkt_o.imm", ex_pkt_o.imm, exp.imm);
				check_word("ex_pkt_o.rs1_data", ex_pkt_o.rs1_data, exp.rs1_data);
				check_word("ex_pkt_o.rs2_data", ex_pkt_o.rs2_data, exp.rs2_data);
				check_word("ex_pkt_o.pc_plus4", ex_pkt_o.pc_plus4, exp.pc_plus4);
				check_pkt("ex_pkt_o", ex_pkt_o, exp);
				issued++;
				ex_outstanding++;
				if (ex_outstanding > rv_decode_pkg::EX_CREDITS) begin
					protocol_error("more packets in flight than execute has credits for");
				end
			end
		end
		if (pending_q.size() > rv_decode_pkg::QUEUE_DEPTH) begin
			protocol_error("fetch has more instructions in flight than the queue holds");
		end
	endtask

	// register data at the issue edge already holds that edge's write
	always @(posedge clk) begin
		if (rst_n_i) begin
			predict_issue();
			shadow_write(wb_i);
			drive_writeback();
			drive_fetch();
			return_credit();
		end
	end

	always @(negedge clk) begin
		if (checking) begin
			check_outputs();
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish, %0d instructions sent", sent);
		report_counts();
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		seed            = 32'h9dda_2e6e;
		rst_n_i         = 1'b0;
		fetch_valid_i   = 1'b0;
		fetch_pkt_i     = '0;
		wb_i            = '0;
		ex_credit_i     = 1'b0;
		next_pc         = 32'h0000_1004;
		last_instr      = '0;
		fetch_credits   = rv_decode_pkg::QUEUE_DEPTH;
		queued          = 0;
		ex_credits_left = rv_decode_pkg::EX_CREDITS;
		issue_exp       = 1'b0;
		shadow_clear();
		@(posedge clk);
		checking = 1'b1;
		repeat (RESET_CYCLES - 1) @(posedge clk);
		rst_n_i <= 1'b1;
		wait (issued == NUM_INSTR && ex_outstanding == 0);
		repeat (4) @(posedge clk);
		if (credit_pulses != issued) begin
			protocol_error("fetch credit pulses do not match the queue pops");
		end
		if (fetch_credits != rv_decode_pkg::QUEUE_DEPTH || pending_q.size() != 0) begin
			protocol_error("fetch did not get all its credits back");
		end
		report_counts();
		if (total_errors() == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* rv_decode.f */
+incdir+bench
logic/rv_decode_pkg.sv
logic/control_unit.sv
logic/reg_bank.sv
logic/imm_gen.sv
logic/instr_queue.sv
logic/id_stage.sv
logic/rv_decode_top.sv
bench/tb_rv_decode.sv

/* Makefile */
# Verilator build and run of the decode stage testbench.

VERILATOR ?= verilator
TOP       ?= tb_rv_decode
FILELIST  ?= rv_decode.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
